// ==== Bender.yml ====
package:
  name: top_tile

sources:
  - logic/tile_cfg_pkg.sv
  - logic/tile_msg_pkg.sv
  - logic/tile_ifs.sv
  - logic/ptw_req_format.sv
  - logic/ptw_lane_tracker.sv
  - logic/ifill_grant_decode.sv
  - logic/pmu_counters.sv
  - logic/top_tile.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_top_tile.sv

// ==== list.f ====
+incdir+testbench
logic/tile_cfg_pkg.sv
logic/tile_msg_pkg.sv
logic/tile_ifs.sv
logic/ptw_req_format.sv
logic/ptw_lane_tracker.sv
logic/ifill_grant_decode.sv
logic/pmu_counters.sv
logic/top_tile.sv
testbench/tb_top_tile.sv

// ==== logic/ifill_grant_decode.sv ====
// Registers the L2 grant for the instruction refill path
// Ack is decoded from the beat number alone, the refill consumer qualifies it with valid

`timescale 1ns/1ps

module ifill_grant_decode
    import tile_cfg_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    io_mem_grant_valid_i,
    input  logic [IFILL_LINE_W-1:0] io_mem_grant_bits_data_i,
    input  logic [1:0]              io_mem_grant_bits_addr_beat_i,
    input  logic                    io_mem_grant_inval_i,
    input  logic [INV_ADDR_W-1:0]   io_mem_grant_inval_addr_i,
    input  logic                    io_core_pmu_l2_hit_i,
    pmu_evt_if.src                  evt,
    output logic                    ifill_valid_o,
    output logic                    ifill_ack_o,
    output logic [IFILL_LINE_W-1:0] ifill_data_o,
    output logic                    ifill_inv_valid_o,
    output logic [INV_ADDR_W-1:0]   ifill_inv_paddr_o
);

    logic l2_hit_q;

    // Control bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ifill_valid_o     <= 1'b0;
            ifill_ack_o       <= 1'b0;
            ifill_inv_valid_o <= 1'b0;
            l2_hit_q          <= 1'b0;
        end else begin
            ifill_valid_o     <= io_mem_grant_valid_i;
            ifill_ack_o       <= (io_mem_grant_bits_addr_beat_i == IFILL_LAST_BEAT);
            ifill_inv_valid_o <= io_mem_grant_inval_i;
            l2_hit_q          <= io_core_pmu_l2_hit_i;
        end
    end

    // Line data and invalidation address
    always_ff @(posedge clk_i) begin
        ifill_data_o      <= io_mem_grant_bits_data_i;
        ifill_inv_paddr_o <= io_mem_grant_inval_addr_i;
    end

    // L2 hit counts once per completed refill
    assign evt.ifill_l2_hit = ifill_ack_o & l2_hit_q;
    assign evt.ifill_inval  = ifill_inv_valid_o;

endmodule

// ==== logic/pmu_counters.sv ====
// Saturating event counters, one per pmu_evt_if pulse
// Counters stop at all ones and only clear on reset

`timescale 1ns/1ps

module pmu_counters
    import tile_cfg_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    pmu_evt_if.sink                 evt,
    output logic [PMU_CNT_W-1:0]    pmu_ptw_req_cnt_o,
    output logic [PMU_CNT_W-1:0]    pmu_l2_hit_cnt_o,
    output logic [PMU_CNT_W-1:0]    pmu_inval_cnt_o
);

    logic [PMU_EVT_N-1:0]   evt_vec;
    logic [PMU_CNT_W-1:0]   cnt_q [PMU_EVT_N];

    // Event order matches the counter outputs below
    assign evt_vec = {evt.ifill_inval, evt.ifill_l2_hit, evt.ptw_req_fire};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PMU_EVT_N; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < PMU_EVT_N; i++) begin
                if (evt_vec[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign pmu_ptw_req_cnt_o = cnt_q[0];
    assign pmu_l2_hit_cnt_o  = cnt_q[1];
    assign pmu_inval_cnt_o   = cnt_q[2];

endmodule

// ==== logic/ptw_lane_tracker.sv ====
// Remembers the lane of each walker request in flight
// Cache responses must return in request order, at most PTW_MAX_INFLIGHT outstanding

`timescale 1ns/1ps

module ptw_lane_tracker
    import tile_cfg_pkg::*, tile_msg_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            dmem_req_ready_i,
    input  logic            dmem_rsp_valid_i,
    input  dc_word_u        dmem_rsp_rdata_i,
    dmem_req_if.mon         req,
    pmu_evt_if.src          evt,
    output logic            ptw_req_ready_o,
    output logic            ptw_rsp_valid_o,
    output logic [63:0]     ptw_rsp_data_o
);

    logic [DC_LANE_W-1:0]   lane_q [PTW_MAX_INFLIGHT];
    logic [PTW_Q_PTR_W-1:0] wr_ptr;
    logic [PTW_Q_PTR_W-1:0] rd_ptr;
    logic [PTW_Q_PTR_W:0]   count;
    logic                   full;
    logic                   push;
    logic                   pop;

    assign full = (count == PTW_MAX_INFLIGHT);

    // Hold the walker off once every queue slot is taken
    assign req.ready       = dmem_req_ready_i & ~full;
    assign ptw_req_ready_o = req.ready;

    assign push = req.valid & req.ready;
    assign pop  = dmem_rsp_valid_i;

    assign evt.ptw_req_fire = push;

    // ----------------------------------------------------------------------
    // Circular lane queue
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            lane_q[wr_ptr] <= req.lane;
        end
    end

    // Oldest lane picks the walker's word out of the response
    assign ptw_rsp_valid_o = dmem_rsp_valid_i;
    assign ptw_rsp_data_o  = dmem_rsp_rdata_i.lane[lane_q[rd_ptr]];

    a_rsp_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dmem_rsp_valid_i |-> (count != '0))
        else $error("cache response with no request in flight");

    // Walker keeps a refused request on the bus unchanged
    a_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (req.valid && !req.ready) |=> (req.valid && $stable(req.lane)))
        else $error("walker request dropped or changed while stalled");

endmodule

// ==== logic/ptw_req_format.sv ====
// Walker request to data cache request, purely combinational
// Only the AMO command writes; all other commands are issued as loads

`timescale 1ns/1ps

module ptw_req_format
    import tile_cfg_pkg::*, tile_msg_pkg::*;
(
    input  logic                    ptw_req_valid_i,
    input  logic [PTW_ADDR_W-1:0]   ptw_req_addr_i,
    input  logic [4:0]              ptw_req_cmd_i,
    input  logic [2:0]              ptw_req_typ_i,
    input  logic [63:0]             ptw_req_data_i,
    dmem_req_if.fmt                 req
);

    logic                       is_amo;
    logic [DC_LANE_W-1:0]       lane;
    dc_word_u                   wdata_d;
    dc_be_u                     be_d;

    assign is_amo = (ptw_req_cmd_i == PTW_AMO_CMD);

    // Lane index sits just above the byte offset of a 64-bit word
    assign lane = ptw_req_addr_i[3 +: DC_LANE_W];

    // Data and enables go only to the addressed lane
    always_comb begin
        wdata_d.flat = '0;
        be_d.flat    = '0;
        wdata_d.lane[lane] = ptw_req_data_i;
        if (is_amo) begin
            be_d.lane[lane] = '1;
        end
    end

    assign req.valid       = ptw_req_valid_i;
    assign req.addr_offset = ptw_req_addr_i[DC_IDX_W-1:0];
    assign req.addr_tag    = ptw_req_addr_i[PTW_ADDR_W-1:DC_IDX_W];
    assign req.op          = is_amo ? DC_OP_AMO_OR : DC_OP_LOAD;
    assign req.size        = ptw_req_typ_i;
    assign req.be          = be_d;
    assign req.wdata       = wdata_d;
    assign req.lane        = lane;

endmodule

// ==== logic/tile_cfg_pkg.sv ====
// Tile configuration constants shared by RTL and testbench
// Walker addresses are physical and 40 bits wide; cache requests carry two 64-bit lanes

package tile_cfg_pkg;

    // ----------------------------------------------------------------------
    // Walker and data cache address split
    // ----------------------------------------------------------------------
    localparam int unsigned PTW_ADDR_W   = 40;
    localparam int unsigned DC_OFFSET_W  = 6;
    localparam int unsigned DC_SET_W     = 6;
    localparam int unsigned DC_IDX_W     = DC_OFFSET_W + DC_SET_W;
    localparam int unsigned DC_TAG_W     = PTW_ADDR_W - DC_IDX_W;

    // Request lanes of 64 bits each
    localparam int unsigned DC_REQ_WORDS = 2;
    localparam int unsigned DC_LANE_W    = 1;

    // Walker command that maps to AMO-OR
    localparam logic [4:0]  PTW_AMO_CMD  = 5'h0A;

    // Lane queue sizing
    localparam int unsigned PTW_MAX_INFLIGHT = 4;
    localparam int unsigned PTW_Q_PTR_W      = $clog2(PTW_MAX_INFLIGHT);

    // ----------------------------------------------------------------------
    // Instruction refill and performance counters
    // ----------------------------------------------------------------------
    localparam int unsigned IFILL_LINE_W    = 512;
    localparam logic [1:0]  IFILL_LAST_BEAT = 2'd3;
    localparam int unsigned INV_ADDR_W      = 12;

    localparam int unsigned PMU_CNT_W = 32;
    localparam int unsigned PMU_EVT_N = 3;

endpackage

// ==== logic/tile_ifs.sv ====
// Internal interfaces of the tile
// Event pulses are one cycle wide and owned by a single source each

`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Formatted data cache request
// ----------------------------------------------------------------------
interface dmem_req_if
    import tile_cfg_pkg::*, tile_msg_pkg::*;
();

    logic                   valid;
    logic                   ready;
    logic [DC_IDX_W-1:0]    addr_offset;
    logic [DC_TAG_W-1:0]    addr_tag;
    dc_op_e                 op;
    logic [2:0]             size;
    dc_be_u                 be;
    dc_word_u               wdata;
    logic [DC_LANE_W-1:0]   lane;

    // Request formatter
    modport fmt (
        output valid, addr_offset, addr_tag, op, size, be, wdata, lane
    );

    // Lane tracker watches the handshake and owns ready
    modport mon (
        input  valid, lane,
        output ready
    );

endinterface

// ----------------------------------------------------------------------
// Performance event pulses
// ----------------------------------------------------------------------
interface pmu_evt_if ();

    logic ptw_req_fire;
    logic ifill_l2_hit;
    logic ifill_inval;

    modport src (
        output ptw_req_fire, ifill_l2_hit, ifill_inval
    );

    modport sink (
        input ptw_req_fire, ifill_l2_hit, ifill_inval
    );

endinterface

// ==== logic/tile_msg_pkg.sv ====
// Message types exchanged with the data cache
// Union views assume lane 0 sits in the low 64 bits of the cache word

package tile_msg_pkg;

    import tile_cfg_pkg::*;

    // Cache operation code
    typedef enum logic [1:0] {
        DC_OP_LOAD   = 2'd0,
        DC_OP_AMO_OR = 2'd1
    } dc_op_e;

    // ----------------------------------------------------------------------
    // Cache data word, seen flat or split into 64-bit lanes
    // ----------------------------------------------------------------------
    typedef union packed {
        logic [DC_REQ_WORDS*64-1:0]       flat;
        logic [DC_REQ_WORDS-1:0][63:0]    lane;
    } dc_word_u;

    // Byte enables, eight per lane
    typedef union packed {
        logic [DC_REQ_WORDS*8-1:0]        flat;
        logic [DC_REQ_WORDS-1:0][7:0]     lane;
    } dc_be_u;

endpackage

// ==== logic/top_tile.sv ====
// Tile top: walker bridge, refill grant decode and event counters
// Cache side has no response ready; responses must match requests in flight

`timescale 1ns/1ps

module top_tile
    import tile_cfg_pkg::*, tile_msg_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    // ----------------------------------------------------------------------
    // Page table walker
    // ----------------------------------------------------------------------
    input  logic                    ptw_req_valid_i,
    output logic                    ptw_req_ready_o,
    input  logic [PTW_ADDR_W-1:0]   ptw_req_addr_i,
    input  logic [4:0]              ptw_req_cmd_i,
    input  logic [2:0]              ptw_req_typ_i,
    input  logic [63:0]             ptw_req_data_i,
    output logic                    ptw_rsp_valid_o,
    output logic [63:0]             ptw_rsp_data_o,

    // ----------------------------------------------------------------------
    // Data cache
    // ----------------------------------------------------------------------
    output logic                    dmem_req_valid_o,
    input  logic                    dmem_req_ready_i,
    output logic [DC_IDX_W-1:0]     dmem_req_addr_offset_o,
    output logic [DC_TAG_W-1:0]     dmem_req_addr_tag_o,
    output dc_op_e                  dmem_req_op_o,
    output logic [2:0]              dmem_req_size_o,
    output dc_be_u                  dmem_req_be_o,
    output dc_word_u                dmem_req_wdata_o,
    input  logic                    dmem_rsp_valid_i,
    input  dc_word_u                dmem_rsp_rdata_i,

    // ----------------------------------------------------------------------
    // L2 grant and refill
    // ----------------------------------------------------------------------
    input  logic                    io_mem_grant_valid_i,
    input  logic [IFILL_LINE_W-1:0] io_mem_grant_bits_data_i,
    input  logic [1:0]              io_mem_grant_bits_addr_beat_i,
    input  logic                    io_mem_grant_inval_i,
    input  logic [INV_ADDR_W-1:0]   io_mem_grant_inval_addr_i,
    input  logic                    io_core_pmu_l2_hit_i,
    output logic                    ifill_valid_o,
    output logic                    ifill_ack_o,
    output logic [IFILL_LINE_W-1:0] ifill_data_o,
    output logic                    ifill_inv_valid_o,
    output logic [INV_ADDR_W-1:0]   ifill_inv_paddr_o,

    // Event counters
    output logic [PMU_CNT_W-1:0]    pmu_ptw_req_cnt_o,
    output logic [PMU_CNT_W-1:0]    pmu_l2_hit_cnt_o,
    output logic [PMU_CNT_W-1:0]    pmu_inval_cnt_o
);

    dmem_req_if dmem_req ();
    pmu_evt_if  pmu_evt ();

    assign dmem_req_valid_o       = dmem_req.valid;
    assign dmem_req_addr_offset_o = dmem_req.addr_offset;
    assign dmem_req_addr_tag_o    = dmem_req.addr_tag;
    assign dmem_req_op_o          = dmem_req.op;
    assign dmem_req_size_o        = dmem_req.size;
    assign dmem_req_be_o          = dmem_req.be;
    assign dmem_req_wdata_o       = dmem_req.wdata;

    ptw_req_format u_ptw_req_format (
        .ptw_req_valid_i ( ptw_req_valid_i ),
        .ptw_req_addr_i  ( ptw_req_addr_i  ),
        .ptw_req_cmd_i   ( ptw_req_cmd_i   ),
        .ptw_req_typ_i   ( ptw_req_typ_i   ),
        .ptw_req_data_i  ( ptw_req_data_i  ),
        .req             ( dmem_req.fmt    )
    );

    ptw_lane_tracker u_ptw_lane_tracker (
        .clk_i            ( clk_i            ),
        .arst_n_i         ( arst_n_i         ),
        .dmem_req_ready_i ( dmem_req_ready_i ),
        .dmem_rsp_valid_i ( dmem_rsp_valid_i ),
        .dmem_rsp_rdata_i ( dmem_rsp_rdata_i ),
        .req              ( dmem_req.mon     ),
        .evt              ( pmu_evt.src      ),
        .ptw_req_ready_o  ( ptw_req_ready_o  ),
        .ptw_rsp_valid_o  ( ptw_rsp_valid_o  ),
        .ptw_rsp_data_o   ( ptw_rsp_data_o   )
    );

    ifill_grant_decode u_ifill_grant_decode (
        .clk_i                         ( clk_i                         ),
        .arst_n_i                      ( arst_n_i                      ),
        .io_mem_grant_valid_i          ( io_mem_grant_valid_i          ),
        .io_mem_grant_bits_data_i      ( io_mem_grant_bits_data_i      ),
        .io_mem_grant_bits_addr_beat_i ( io_mem_grant_bits_addr_beat_i ),
        .io_mem_grant_inval_i          ( io_mem_grant_inval_i          ),
        .io_mem_grant_inval_addr_i     ( io_mem_grant_inval_addr_i     ),
        .io_core_pmu_l2_hit_i          ( io_core_pmu_l2_hit_i          ),
        .evt                           ( pmu_evt.src                   ),
        .ifill_valid_o                 ( ifill_valid_o                 ),
        .ifill_ack_o                   ( ifill_ack_o                   ),
        .ifill_data_o                  ( ifill_data_o                  ),
        .ifill_inv_valid_o             ( ifill_inv_valid_o             ),
        .ifill_inv_paddr_o             ( ifill_inv_paddr_o             )
    );

    pmu_counters u_pmu_counters (
        .clk_i             ( clk_i             ),
        .arst_n_i          ( arst_n_i          ),
        .evt               ( pmu_evt.sink      ),
        .pmu_ptw_req_cnt_o ( pmu_ptw_req_cnt_o ),
        .pmu_l2_hit_cnt_o  ( pmu_l2_hit_cnt_o  ),
        .pmu_inval_cnt_o   ( pmu_inval_cnt_o   )
    );

endmodule

// ==== testbench/tb_model.svh ====
// Reference model of the tile, included inside the testbench module
// Reads the testbench's input variables, so it must follow their declarations

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Lanes of walker requests in flight, oldest first
logic [DC_LANE_W-1:0]       m_lanes [$];

// Registered grant fields and the counters
logic                       m_valid;
logic                       m_ack;
logic                       m_inv_valid;
logic                       m_l2_hit;
logic [IFILL_LINE_W-1:0]    m_data;
logic [INV_ADDR_W-1:0]      m_inv_addr;
logic [PMU_CNT_W-1:0]       m_ptw_cnt;
logic [PMU_CNT_W-1:0]       m_l2_cnt;
logic [PMU_CNT_W-1:0]       m_inv_cnt;

function automatic void clear_model();
    m_lanes.delete();
    m_valid     = 1'b0;
    m_ack       = 1'b0;
    m_inv_valid = 1'b0;
    m_l2_hit    = 1'b0;
    m_data      = '0;
    m_inv_addr  = '0;
    m_ptw_cnt   = '0;
    m_l2_cnt    = '0;
    m_inv_cnt   = '0;
endfunction

// AMO-OR only for the one walker command, everything else loads
function automatic dc_op_e op_for_cmd(logic [4:0] cmd);
    return (cmd == PTW_AMO_CMD) ? DC_OP_AMO_OR : DC_OP_LOAD;
endfunction

// Lane 0 is the low 64 bits, picked by address bit 3
function automatic dc_be_u be_for_req(logic [4:0] cmd, logic [PTW_ADDR_W-1:0] addr);
    dc_be_u be;
    int     lane;
    lane    = addr[3];
    be.flat = '0;
    if (cmd == PTW_AMO_CMD) begin
        be.flat[lane*8 +: 8] = 8'hff;
    end
    return be;
endfunction

function automatic dc_word_u wdata_for_req(logic [PTW_ADDR_W-1:0] addr, logic [63:0] data);
    dc_word_u wd;
    int       lane;
    lane    = addr[3];
    wd.flat = '0;
    wd.flat[lane*64 +: 64] = data;
    return wd;
endfunction

// Word of a response that belongs to the oldest request
function automatic logic [63:0] lane_word(dc_word_u rdata);
    int lane;
    lane = m_lanes[0];
    return rdata.flat[lane*64 +: 64];
endfunction

function automatic logic walker_ready();
    return dmem_req_ready_i && (m_lanes.size() < PTW_MAX_INFLIGHT);
endfunction

function automatic logic [PMU_CNT_W-1:0] sat_inc(logic [PMU_CNT_W-1:0] cnt, logic evt);
    if (evt && (cnt != '1)) begin
        return cnt + 1'b1;
    end
    return cnt;
endfunction

// One rising edge, using the inputs held during the cycle that ends
task automatic advance_model();
    logic accept;
    accept    = ptw_req_valid_i && walker_ready();
    m_ptw_cnt = sat_inc(m_ptw_cnt, accept);
    m_l2_cnt  = sat_inc(m_l2_cnt, m_ack && m_l2_hit);
    m_inv_cnt = sat_inc(m_inv_cnt, m_inv_valid);
    if (dmem_rsp_valid_i && (m_lanes.size() != 0)) begin
        void'(m_lanes.pop_front());
    end
    if (accept) begin
        m_lanes.push_back(ptw_req_addr_i[3]);
    end
    m_valid     = io_mem_grant_valid_i;
    m_ack       = (io_mem_grant_bits_addr_beat_i == IFILL_LAST_BEAT);
    m_inv_valid = io_mem_grant_inval_i;
    m_l2_hit    = io_core_pmu_l2_hit_i;
    m_data      = io_mem_grant_bits_data_i;
    m_inv_addr  = io_mem_grant_inval_addr_i;
endtask

`endif

// ==== testbench/tb_top_tile.sv ====
// Random walker, in-order cache stub and random L2 grants against a reference model
// Inputs change on the rising edge and outputs are compared on the falling edge

`timescale 1ns/1ps

module tb_top_tile
    import tile_cfg_pkg::*, tile_msg_pkg::*;
();

    localparam int unsigned STIM_CYCLES = 2000;
    localparam int unsigned MAX_CYCLES  = 3000;

    logic                       clk_i = 1'b0;
    logic                       arst_n_i;
    logic                       ptw_req_valid_i;
    logic                       ptw_req_ready_o;
    logic [PTW_ADDR_W-1:0]      ptw_req_addr_i;
    logic [4:0]                 ptw_req_cmd_i;
    logic [2:0]                 ptw_req_typ_i;
    logic [63:0]                ptw_req_data_i;
    logic                       ptw_rsp_valid_o;
    logic [63:0]                ptw_rsp_data_o;
    logic                       dmem_req_valid_o;
    logic                       dmem_req_ready_i;
    logic [DC_IDX_W-1:0]        dmem_req_addr_offset_o;
    logic [DC_TAG_W-1:0]        dmem_req_addr_tag_o;
    dc_op_e                     dmem_req_op_o;
    logic [2:0]                 dmem_req_size_o;
    dc_be_u                     dmem_req_be_o;
    dc_word_u                   dmem_req_wdata_o;
    logic                       dmem_rsp_valid_i;
    dc_word_u                   dmem_rsp_rdata_i;
    logic                       io_mem_grant_valid_i;
    logic [IFILL_LINE_W-1:0]    io_mem_grant_bits_data_i;
    logic [1:0]                 io_mem_grant_bits_addr_beat_i;
    logic                       io_mem_grant_inval_i;
    logic [INV_ADDR_W-1:0]      io_mem_grant_inval_addr_i;
    logic                       io_core_pmu_l2_hit_i;
    logic                       ifill_valid_o;
    logic                       ifill_ack_o;
    logic [IFILL_LINE_W-1:0]    ifill_data_o;
    logic                       ifill_inv_valid_o;
    logic [INV_ADDR_W-1:0]      ifill_inv_paddr_o;
    logic [PMU_CNT_W-1:0]       pmu_ptw_req_cnt_o;
    logic [PMU_CNT_W-1:0]       pmu_l2_hit_cnt_o;
    logic [PMU_CNT_W-1:0]       pmu_inval_cnt_o;

    integer         seed      = 32'h9da4;
    int unsigned    cycle_cnt = 0;
    logic           stim_on;
    logic           req_held;

    `include "tb_model.svh"

    always #10 clk_i = ~clk_i;

    top_tile u_top_tile (.*);

    task automatic fail_run(string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: run still going after %0d cycles", MAX_CYCLES));
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_req(logic [1:0] got_hs, logic [1:0] exp_hs,
                             logic [PTW_ADDR_W-1:0] got_addr, logic [PTW_ADDR_W-1:0] exp_addr,
                             logic [2:0] got_size, logic [2:0] exp_size,
                             dc_op_e got_op, dc_op_e exp_op, dc_be_u got_be, dc_be_u exp_be,
                             dc_word_u got_wd, dc_word_u exp_wd);
        if (got_hs !== exp_hs) begin
            fail_run($sformatf("Mismatch at %0t: valid/ready %b, expected %b",
                               $time, got_hs, exp_hs));
        end
        if ((got_addr !== exp_addr) || (got_size !== exp_size)) begin
            fail_run($sformatf("Mismatch at %0t: tag/offset %h size %0d, expected %h size %0d",
                               $time, got_addr, got_size, exp_addr, exp_size));
        end
        if ((got_op !== exp_op) || (got_be !== exp_be) || (got_wd !== exp_wd)) begin
            fail_run($sformatf("Mismatch at %0t: op %0d be %h wdata %h, expected %0d %h %h",
                               $time, got_op, got_be, got_wd, exp_op, exp_be, exp_wd));
        end
    endtask

    task automatic check_rsp(logic got_valid, logic exp_valid,
                             logic [63:0] got_data, logic [63:0] exp_data);
        if (got_valid !== exp_valid) begin
            fail_run($sformatf("Mismatch at %0t: ptw_rsp_valid_o %b, expected %b",
                               $time, got_valid, exp_valid));
        end
        if (exp_valid && (got_data !== exp_data)) begin
            fail_run($sformatf("Mismatch at %0t: ptw_rsp_data_o %h, expected %h",
                               $time, got_data, exp_data));
        end
    endtask

    task automatic check_fill(string what, logic [IFILL_LINE_W-1:0] got,
                              logic [IFILL_LINE_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_cnt(string what, logic [PMU_CNT_W-1:0] got, logic [PMU_CNT_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_outputs();
        logic [63:0] rsp_exp;
        rsp_exp = '0;
        if (dmem_rsp_valid_i && (m_lanes.size() != 0)) begin
            rsp_exp = lane_word(dmem_rsp_rdata_i);
        end
        check_req({dmem_req_valid_o, ptw_req_ready_o}, {ptw_req_valid_i, walker_ready()},
                  {dmem_req_addr_tag_o, dmem_req_addr_offset_o}, ptw_req_addr_i,
                  dmem_req_size_o, ptw_req_typ_i,
                  dmem_req_op_o, op_for_cmd(ptw_req_cmd_i),
                  dmem_req_be_o, be_for_req(ptw_req_cmd_i, ptw_req_addr_i),
                  dmem_req_wdata_o, wdata_for_req(ptw_req_addr_i, ptw_req_data_i));
        check_rsp(ptw_rsp_valid_o, dmem_rsp_valid_i, ptw_rsp_data_o, rsp_exp);
        check_fill("ifill_valid_o", ifill_valid_o, m_valid);
        check_fill("ifill_ack_o", ifill_ack_o, m_ack);
        check_fill("ifill_data_o", ifill_data_o, m_data);
        check_fill("ifill_inv_valid_o", ifill_inv_valid_o, m_inv_valid);
        check_fill("ifill_inv_paddr_o", ifill_inv_paddr_o, m_inv_addr);
        check_cnt("pmu_ptw_req_cnt_o", pmu_ptw_req_cnt_o, m_ptw_cnt);
        check_cnt("pmu_l2_hit_cnt_o", pmu_l2_hit_cnt_o, m_l2_cnt);
        check_cnt("pmu_inval_cnt_o", pmu_inval_cnt_o, m_inv_cnt);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and cache stub
    // ----------------------------------------------------------------------
    task automatic drive_inputs();
        logic [IFILL_LINE_W-1:0] line;
        for (int i = 0; i < IFILL_LINE_W / 32; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
        // Payload stays put until the request is taken
        if (!req_held) begin
            ptw_req_valid_i <= stim_on && (($random(seed) & 3) != 0);
            ptw_req_addr_i  <= PTW_ADDR_W'({$random(seed), $random(seed)});
            ptw_req_cmd_i   <= ($random(seed) & 1) ? PTW_AMO_CMD : 5'($random(seed));
            ptw_req_typ_i   <= 3'($random(seed));
            ptw_req_data_i  <= {$random(seed), $random(seed)};
        end
        dmem_req_ready_i <= (($random(seed) & 3) != 0);
        // Stub answers in order, never more than is outstanding
        dmem_rsp_valid_i <= (m_lanes.size() != 0) && (($random(seed) & 1) != 0);
        dmem_rsp_rdata_i.flat <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        io_mem_grant_valid_i          <= stim_on && (($random(seed) & 1) != 0);
        io_mem_grant_bits_data_i      <= line;
        io_mem_grant_bits_addr_beat_i <= 2'($random(seed));
        io_mem_grant_inval_i          <= stim_on && (($random(seed) & 3) == 0);
        io_mem_grant_inval_addr_i     <= INV_ADDR_W'($random(seed));
        io_core_pmu_l2_hit_i          <= (($random(seed) & 1) != 0);
    endtask

    task automatic step_cycle();
        @(negedge clk_i);
        check_outputs();
        @(posedge clk_i);
        req_held = ptw_req_valid_i && !walker_ready();
        advance_model();
        drive_inputs();
    endtask

    initial begin
        arst_n_i                      = 1'b0;
        ptw_req_valid_i               = 1'b0;
        ptw_req_addr_i                = '0;
        ptw_req_cmd_i                 = '0;
        ptw_req_typ_i                 = '0;
        ptw_req_data_i                = '0;
        dmem_req_ready_i              = 1'b0;
        dmem_rsp_valid_i              = 1'b0;
        dmem_rsp_rdata_i              = '0;
        io_mem_grant_valid_i          = 1'b0;
        io_mem_grant_bits_data_i      = '0;
        io_mem_grant_bits_addr_beat_i = '0;
        io_mem_grant_inval_i          = 1'b0;
        io_mem_grant_inval_addr_i     = '0;
        io_core_pmu_l2_hit_i          = 1'b0;
        stim_on                       = 1'b0;
        req_held                      = 1'b0;
        clear_model();

        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        stim_on = 1'b1;
        drive_inputs();

        for (int i = 0; i < STIM_CYCLES; i++) begin
            step_cycle();
        end

        // Drain the walker and the cache stub
        stim_on = 1'b0;
        while ((m_lanes.size() != 0) || ptw_req_valid_i) begin
            step_cycle();
        end
        repeat (3) step_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule
